/* include/obi_mem_cfg.svh */
// ----------------------------------------------------------------------
// OBI memory configuration
// Sizes shared by the memory controller, protocol monitor and CSR block
// ----------------------------------------------------------------------

`ifndef OBI_MEM_CFG_SVH
`define OBI_MEM_CFG_SVH

// Byte address width of the OBI request port
`define OBI_ADDR_WIDTH 32

// Number of 32-bit words held in the array
`define OBI_MEM_WORDS 256

// Width of the rotating grant stall pattern
`define OBI_STALL_WIDTH 8

`endif

/* hdl/obi_mem_pkg.sv */
// ----------------------------------------------------------------------
// OBI memory package
// Violation codes of the protocol monitor and CSR register addresses
// ----------------------------------------------------------------------

package obi_mem_pkg;

  // Violation codes, listed from highest to lowest priority
  // RULE_NONE means no rule was broken in the sampled cycle
  typedef enum logic [3:0] {
    RULE_NONE             = 4'd0,
    RULE_ADDR_UNSTABLE    = 4'd1,
    RULE_WE_UNSTABLE      = 4'd2,
    RULE_BE_UNSTABLE      = 4'd3,
    RULE_WDATA_UNSTABLE   = 4'd4,
    RULE_REQ_DROPPED      = 4'd5,
    RULE_BE_ZERO          = 4'd6,
    RULE_BE_GAP           = 4'd7,
    RULE_ADDR_BE_MISMATCH = 4'd8
  } obi_rule_e;

  // Configuration register map
  // The stall pattern is read/write, the two status registers are
  // cleared together by a write to the count register
  typedef enum logic [1:0] {
    CSR_STALL      = 2'd0,
    CSR_VIOL_COUNT = 2'd1,
    CSR_FIRST_VIOL = 2'd2
  } obi_csr_e;

endpackage

/* hdl/obi_mem_ctrl.sv */
// ----------------------------------------------------------------------
// OBI memory controller
// Grants requests from a rotating stall pattern, holds a word array with
// byte-enabled writes and returns each response one cycle after accept
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "obi_mem_cfg.svh"

module obi_mem_ctrl (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        req,
  input  logic                        we,
  input  logic [`OBI_ADDR_WIDTH-1:0]  addr,
  input  logic [3:0]                  be,
  input  logic [31:0]                 wdata,
  input  logic [`OBI_STALL_WIDTH-1:0] stall_pattern,
  output logic                        gnt,
  output logic                        rvalid,
  output logic                        err,
  output logic [31:0]                 rdata
);

  localparam int IDX_W   = $clog2(`OBI_MEM_WORDS);
  localparam int WORD_AW = `OBI_ADDR_WIDTH - 2;

  // ------------------------------------------------------------------
  // Grant generation
  // ------------------------------------------------------------------

  // Working copy of the pattern, rotated right once per cycle
  logic [`OBI_STALL_WIDTH-1:0] pattern_q;
  // Last CSR value seen, used to spot a new pattern
  logic [`OBI_STALL_WIDTH-1:0] stall_last_q;
  logic                        reload;

  assign reload = (stall_pattern != stall_last_q);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pattern_q    <= '0;
      stall_last_q <= '0;
    end else begin
      stall_last_q <= stall_pattern;
      // A new CSR value restarts the rotation from its bit 0
      if (reload) begin
        pattern_q <= stall_pattern;
      end else begin
        pattern_q <= {pattern_q[0], pattern_q[`OBI_STALL_WIDTH-1:1]};
      end
    end
  end

  // A set pattern bit stalls the current cycle, so all zeros never stalls
  assign gnt = ~pattern_q[0];

  // ------------------------------------------------------------------
  // Address decode and array
  // ------------------------------------------------------------------

  logic                  accept;
  logic [WORD_AW-1:0]    word_addr;
  logic [IDX_W-1:0]      word_idx;
  logic                  in_range;
  logic [31:0]           mem [`OBI_MEM_WORDS];

  assign accept    = req && gnt;
  assign word_addr = addr[`OBI_ADDR_WIDTH-1:2];
  assign word_idx  = word_addr[IDX_W-1:0];
  // Anything past the last word is an error and must not alias into the array
  assign in_range  = (word_addr < WORD_AW'(`OBI_MEM_WORDS));

  always_ff @(posedge clk) begin
    if (accept && we && in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Response stage
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid <= 1'b0;
      err    <= 1'b0;
    end else begin
      rvalid <= accept;
      err    <= accept && !in_range;
    end
  end

  // Writes and failed reads return zero data
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata <= (!we && in_range) ? mem[word_idx] : 32'h0;
    end
  end

  // Every response belongs to a phase accepted on the previous edge
  a_rvalid_after_accept : assert property (
    @(posedge clk) disable iff (!reset_n)
    rvalid |-> $past(req && gnt)
  ) else $error("rvalid without an accepted address phase");

  // A pattern that has been zero for at least one edge never stalls
  a_gnt_from_pattern : assert property (
    @(posedge clk) disable iff (!reset_n)
    ((stall_pattern == '0) && (stall_last_q == '0)) |-> gnt
  ) else $error("gnt does not follow the stall pattern");

endmodule

/* hdl/obi_protocol_monitor.sv */
// ----------------------------------------------------------------------
// OBI protocol monitor
// Checks the request side against the address phase rules and reports
// the highest priority broken rule as a one-cycle pulse with its code
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "obi_mem_cfg.svh"

module obi_protocol_monitor (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       req,
  input  logic                       gnt,
  input  logic                       we,
  input  logic [`OBI_ADDR_WIDTH-1:0] addr,
  input  logic [3:0]                 be,
  input  logic [31:0]                wdata,
  output logic                       violation,
  output obi_mem_pkg::obi_rule_e     violation_code
);

  import obi_mem_pkg::*;

  // Index of the lowest enabled byte
  // An empty mask gives zero, so only a nonzero offset is flagged then
  function automatic logic [1:0] lowest_be(input logic [3:0] mask);
    casez (mask)
      4'b???1: return 2'd0;
      4'b??10: return 2'd1;
      4'b?100: return 2'd2;
      4'b1000: return 2'd3;
      default: return 2'd0;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Previous cycle sample
  // ------------------------------------------------------------------

  logic [`OBI_ADDR_WIDTH-1:0] addr_q;
  logic                       we_q;
  logic [3:0]                 be_q;
  logic [31:0]                wdata_q;
  // Set when the last cycle had a request that was not granted
  logic                       waiting_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      waiting_q <= 1'b0;
    end else begin
      waiting_q <= req && !gnt;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= addr;
    we_q    <= we;
    be_q    <= be;
    wdata_q <= wdata;
  end

  // ------------------------------------------------------------------
  // Rule evaluation
  // ------------------------------------------------------------------

  logic       hold_chk;
  logic [4:0] be_fill;
  logic       be_gap;
  obi_rule_e  rule_next;

  // Stability is only judged while the request is still pending
  assign hold_chk = waiting_q && req;

  // Filling the trailing zeros and adding one clears a single run of ones,
  // so any bit left over in the AND marks a second run
  assign be_fill = ({1'b0, be} | ({1'b0, be} - 5'd1)) + 5'd1;
  assign be_gap  = |(be_fill & {1'b0, be});

  // Earlier branches win, matching the order of the code values
  always_comb begin
    rule_next = RULE_NONE;
    if (hold_chk && (addr != addr_q)) begin
      rule_next = RULE_ADDR_UNSTABLE;
    end else if (hold_chk && (we != we_q)) begin
      rule_next = RULE_WE_UNSTABLE;
    end else if (hold_chk && (be != be_q)) begin
      rule_next = RULE_BE_UNSTABLE;
    end else if (hold_chk && we_q && (wdata != wdata_q)) begin
      // Write data only carries meaning for a pending write
      rule_next = RULE_WDATA_UNSTABLE;
    end else if (waiting_q && !req) begin
      rule_next = RULE_REQ_DROPPED;
    end else if (req && we && (be == 4'b0000)) begin
      rule_next = RULE_BE_ZERO;
    end else if (req && we && be_gap) begin
      rule_next = RULE_BE_GAP;
    end else if (req && (addr[1:0] > lowest_be(be))) begin
      rule_next = RULE_ADDR_BE_MISMATCH;
    end
  end

  // ------------------------------------------------------------------
  // Registered report
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      violation      <= 1'b0;
      violation_code <= RULE_NONE;
    end else begin
      violation      <= (rule_next != RULE_NONE);
      violation_code <= rule_next;
    end
  end

  // A pulse needs a request or a pending request in the sampled cycle
  a_code_idle : assert property (
    @(posedge clk) disable iff (!reset_n)
    violation |-> $past(req || waiting_q)
  ) else $error("violation reported without any request activity");

endmodule

/* hdl/obi_mem_csr.sv */
// ----------------------------------------------------------------------
// OBI memory configuration and status registers
// Holds the grant stall pattern, a violation count and the first code
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "obi_mem_cfg.svh"

module obi_mem_csr (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        cfg_sel,
  input  logic                        cfg_we,
  input  obi_mem_pkg::obi_csr_e       cfg_addr,
  input  logic [31:0]                 cfg_wdata,
  output logic [31:0]                 cfg_rdata,
  input  logic                        violation,
  input  obi_mem_pkg::obi_rule_e      violation_code,
  output logic [`OBI_STALL_WIDTH-1:0] stall_pattern
);

  import obi_mem_pkg::*;

  logic      wr_stall;
  logic      clr_count;
  logic [15:0] count_q;
  obi_rule_e first_q;

  assign wr_stall  = cfg_sel && cfg_we && (cfg_addr == CSR_STALL);
  // One write to the count register clears both status fields
  assign clr_count = cfg_sel && cfg_we && (cfg_addr == CSR_VIOL_COUNT);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stall_pattern <= '0;
      count_q       <= 16'h0;
      first_q       <= RULE_NONE;
    end else begin
      if (wr_stall) begin
        stall_pattern <= cfg_wdata[`OBI_STALL_WIDTH-1:0];
      end
      // A clear wins over a violation reported on the same edge
      if (clr_count) begin
        count_q <= 16'h0;
        first_q <= RULE_NONE;
      end else if (violation) begin
        if (count_q != 16'hffff) begin
          count_q <= count_q + 16'h1;
        end
        if (first_q == RULE_NONE) begin
          first_q <= violation_code;
        end
      end
    end
  end

  // Read mux, bits beyond each field read as zero
  always_comb begin
    case (cfg_addr)
      CSR_STALL:      cfg_rdata = {{(32-`OBI_STALL_WIDTH){1'b0}}, stall_pattern};
      CSR_VIOL_COUNT: cfg_rdata = {16'h0, count_q};
      CSR_FIRST_VIOL: cfg_rdata = {28'h0, first_q};
      default:        cfg_rdata = 32'h0;
    endcase
  end

  // The counter only ever moves down through a clearing write
  a_count_monotonic : assert property (
    @(posedge clk) disable iff (!reset_n)
    !$past(clr_count) |-> (count_q >= $past(count_q))
  ) else $error("violation count decreased without a clear");

endmodule

/* hdl/obi_mem_top.sv */
// ----------------------------------------------------------------------
// OBI memory top level
// Memory controller, protocol monitor and configuration registers
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "obi_mem_cfg.svh"

module obi_mem_top (
  input  logic                       clk,
  input  logic                       reset_n,
  // OBI request side
  input  logic                       req,
  input  logic [`OBI_ADDR_WIDTH-1:0] addr,
  input  logic                       we,
  input  logic [3:0]                 be,
  input  logic [31:0]                wdata,
  output logic                       gnt,
  // OBI response side
  output logic                       rvalid,
  output logic [31:0]                rdata,
  output logic                       err,
  // Configuration port
  input  logic                       cfg_sel,
  input  logic                       cfg_we,
  input  obi_mem_pkg::obi_csr_e      cfg_addr,
  input  logic [31:0]                cfg_wdata,
  output logic [31:0]                cfg_rdata,
  // Protocol violation report
  output logic                       violation,
  output obi_mem_pkg::obi_rule_e     violation_code
);

  // Pattern from the CSR block into the grant logic
  logic [`OBI_STALL_WIDTH-1:0] stall_pattern;

  obi_mem_ctrl ctrl_i (
    .clk, .reset_n, .req, .we, .addr, .be, .wdata,
    .stall_pattern, .gnt, .rvalid, .err, .rdata
  );

  // The monitor sees the grant the controller is driving this cycle
  obi_protocol_monitor monitor_i (
    .clk, .reset_n, .req, .gnt, .we, .addr, .be, .wdata,
    .violation, .violation_code
  );

  obi_mem_csr csr_i (
    .clk, .reset_n, .cfg_sel, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .violation, .violation_code, .stall_pattern
  );

endmodule

/* verif/obi_mem_tb.sv */
// ----------------------------------------------------------------------
// OBI memory testbench
// Drives legal and illegal OBI traffic and config accesses, and checks
// responses, grant stalls and violation reports against a model
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "obi_mem_cfg.svh"

module obi_mem_tb;

  import obi_mem_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int IDX_W   = $clog2(`OBI_MEM_WORDS);

  logic                       clk;
  logic                       reset_n;
  logic                       req;
  logic [`OBI_ADDR_WIDTH-1:0] addr;
  logic                       we;
  logic [3:0]                 be;
  logic [31:0]                wdata;
  logic                       gnt;
  logic                       rvalid;
  logic [31:0]                rdata;
  logic                       err;
  logic                       cfg_sel;
  logic                       cfg_we;
  obi_csr_e                   cfg_addr;
  logic [31:0]                cfg_wdata;
  logic [31:0]                cfg_rdata;
  logic                       violation;
  obi_rule_e                  violation_code;

  obi_mem_top dut_i (.*);

  int          seed = 32'hb7f8_e432;
  int          errors;
  int          timeouts;
  int          cyc = 0;
  int          viol_seen;
  int          viol_injected;
  obi_rule_e   first_code;
  string       test_name;
  // Shadow of the array, updated in accept order
  logic [31:0] shadow [`OBI_MEM_WORDS];
  // Expected responses, one entry per accepted address phase
  logic [31:0] exp_data_q [$];
  logic        exp_err_q [$];
  int          exp_cyc_q [$];

  initial clk = 1'b0;
  always #10 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // ------------------------------------------------------------------
  // Checks and reference model
  // ------------------------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v === exp_v) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_timeout(input int waited, input string what);
    assert (waited < TIMEOUT) else begin
      $display("%s: gave up waiting for %s", test_name, what);
      timeouts++;
    end
  endtask

  // Violation code from the address phase rules, highest priority first
  // The _p arguments hold the previous cycle, waiting means req without gnt there
  function automatic obi_rule_e expected_rule(
    input logic waiting, input logic req_v, input logic we_v, input logic we_p,
    input logic [31:0] addr_v, input logic [31:0] addr_p,
    input logic [3:0] be_v, input logic [3:0] be_p,
    input logic [31:0] wdata_v, input logic [31:0] wdata_p);
    int runs;
    int low;
    runs = be_v[0] ? 1 : 0;
    low  = 0;
    // Each rising step in the mask starts a new run of ones
    for (int i = 1; i < 4; i++) begin
      if (be_v[i] && !be_v[i-1]) runs++;
    end
    for (int i = 3; i >= 0; i--) begin
      if (be_v[i]) low = i;
    end
    if (waiting && req_v && (addr_v != addr_p)) return RULE_ADDR_UNSTABLE;
    if (waiting && req_v && (we_v != we_p)) return RULE_WE_UNSTABLE;
    if (waiting && req_v && (be_v != be_p)) return RULE_BE_UNSTABLE;
    if (waiting && req_v && we_p && (wdata_v != wdata_p)) return RULE_WDATA_UNSTABLE;
    if (waiting && !req_v) return RULE_REQ_DROPPED;
    if (req_v && we_v && (be_v == 4'b0000)) return RULE_BE_ZERO;
    if (req_v && we_v && (runs > 1)) return RULE_BE_GAP;
    if (req_v && (int'(addr_v[1:0]) > low)) return RULE_ADDR_BE_MISMATCH;
    return RULE_NONE;
  endfunction

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  // One run of ones at a random start and length
  function automatic logic [3:0] random_be();
    logic [31:0] r;
    int          s;
    int          l;
    logic [3:0]  b;
    r = next_random();
    s = r % 4;
    l = (r >> 2) % (4 - s) + 1;
    for (int i = 0; i < 4; i++) begin
      b[i] = (i >= s) && (i < s + l);
    end
    return b;
  endfunction

  // Every response is matched in order, one cycle after its accept
  always @(negedge clk) begin
    if (reset_n && violation) begin
      viol_seen++;
    end
    if (reset_n && rvalid) begin
      assert (exp_data_q.size() != 0) else begin
        $display("%s: rvalid arrived with no outstanding request", test_name);
        errors++;
      end
      if (exp_data_q.size() != 0) begin
        check_value("rdata", exp_data_q.pop_front(), rdata);
        check_value("err", {31'h0, exp_err_q.pop_front()}, {31'h0, err});
        check_value("response cycle", exp_cyc_q.pop_front() + 1, cyc);
      end
    end
  end

  // ------------------------------------------------------------------
  // Drivers, all called and returning on a falling edge
  // ------------------------------------------------------------------

  task automatic obi_xfer(input logic we_v, input logic [31:0] addr_v,
                          input logic [3:0] be_v, input logic [31:0] wdata_v);
    int               waited;
    logic             in_range;
    logic [IDX_W-1:0] idx;
    in_range = (addr_v >> 2) < `OBI_MEM_WORDS;
    idx      = addr_v[IDX_W+1:2];
    req      = 1'b1;
    we       = we_v;
    addr     = addr_v;
    be       = be_v;
    wdata    = wdata_v;
    waited   = 0;
    // gnt is settled here and holds until the next rising edge
    while (!gnt && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    check_timeout(waited, "a grant");
    if (gnt) begin
      exp_data_q.push_back((we_v || !in_range) ? 32'h0 : shadow[idx]);
      exp_err_q.push_back(!in_range);
      exp_cyc_q.push_back(cyc);
      if (we_v && in_range) begin
        for (int i = 0; i < 4; i++) begin
          if (be_v[i]) shadow[idx][8*i +: 8] = wdata_v[8*i +: 8];
        end
      end
      @(negedge clk);
    end
    req = 1'b0;
  endtask

  task automatic cfg_write(input obi_csr_e a, input logic [31:0] d);
    cfg_sel   = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_sel = 1'b0;
    cfg_we  = 1'b0;
  endtask

  task automatic cfg_read(input obi_csr_e a, output logic [31:0] d);
    cfg_sel  = 1'b1;
    cfg_we   = 1'b0;
    cfg_addr = a;
    @(negedge clk);
    d       = cfg_rdata;
    cfg_sel = 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    check_timeout(waited, "outstanding responses");
  endtask

  // Looks at the current edge first, since a pulse may already be showing
  task automatic expect_violation(input obi_rule_e code);
    int waited;
    waited = 0;
    while (!violation && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    check_timeout(waited, "a violation pulse");
    check_value("violation code", {28'h0, code}, {28'h0, violation_code});
    if (viol_injected == 0) first_code = code;
    viol_injected++;
  endtask

  // Changes the pending phase under a full stall, where gnt stays low
  task automatic drive_stalled(input logic req_v, input logic [31:0] addr_v,
                               input logic [3:0] be_v, input logic [31:0] wdata_v);
    obi_rule_e code;
    code  = expected_rule(req && !gnt, req_v, we, we, addr_v, addr, be_v, be, wdata_v, wdata);
    req   = req_v;
    addr  = addr_v;
    be    = be_v;
    wdata = wdata_v;
    @(negedge clk);
    expect_violation(code);
  endtask

  task automatic xfer_violation(input logic we_v, input logic [31:0] addr_v,
                                input logic [3:0] be_v, input logic [31:0] wdata_v);
    obi_xfer(we_v, addr_v, be_v, wdata_v);
    expect_violation(expected_rule(1'b0, 1'b1, we_v, we_v, addr_v, addr_v,
                                   be_v, be_v, wdata_v, wdata_v));
  endtask

  // Over one full rotation the stalled cycles match the set pattern bits
  task automatic check_stall_window(input logic [`OBI_STALL_WIDTH-1:0] pat);
    int ones;
    int lows;
    ones = 0;
    lows = 0;
    for (int i = 0; i < `OBI_STALL_WIDTH; i++) begin
      if (pat[i]) ones++;
    end
    for (int i = 0; i < `OBI_STALL_WIDTH; i++) begin
      if (!gnt) lows++;
      @(negedge clk);
    end
    check_value("gnt low cycles", ones, lows);
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------

  initial begin
    logic [31:0]                 rd;
    logic [31:0]                 r;
    logic [31:0]                 a;
    logic [`OBI_STALL_WIDTH-1:0] pat;
    logic [31:0]                 addr_list [$];
    errors        = 0;
    timeouts      = 0;
    viol_seen     = 0;
    viol_injected = 0;
    first_code    = RULE_NONE;
    test_name     = "reset";
    reset_n       = 1'b0;
    req           = 1'b0;
    addr          = '0;
    we            = 1'b0;
    be            = 4'h0;
    wdata         = 32'h0;
    cfg_sel       = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = CSR_STALL;
    cfg_wdata     = 32'h0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Full words first so every later read has known contents
    test_name = "word_rw";
    for (int n = 0; n < 16; n++) begin
      a = (next_random() % `OBI_MEM_WORDS) * 4;
      addr_list.push_back(a);
      obi_xfer(1'b1, a, 4'hf, next_random());
    end
    for (int n = 0; n < 16; n++) begin
      obi_xfer(1'b1, addr_list[n], random_be(), next_random());
    end
    foreach (addr_list[n]) begin
      obi_xfer(1'b0, addr_list[n], 4'hf, 32'h0);
    end
    wait_responses();

    test_name = "stall_rw";
    for (int p = 0; p < 4; p++) begin
      r   = next_random();
      pat = r[`OBI_STALL_WIDTH-1:0];
      if (pat == '0) pat[0] = 1'b1;
      cfg_write(CSR_STALL, {{(32-`OBI_STALL_WIDTH){1'b0}}, pat});
      // The read takes one more edge, so the controller has reloaded by now
      cfg_read(CSR_STALL, rd);
      check_value("stall readback", {{(32-`OBI_STALL_WIDTH){1'b0}}, pat}, rd);
      check_stall_window(pat);
      check_stall_window(pat);
      for (int n = 0; n < 8; n++) begin
        obi_xfer(1'b1, addr_list[n], random_be(), next_random());
        obi_xfer(1'b0, addr_list[n], 4'hf, 32'h0);
      end
      wait_responses();
    end
    cfg_write(CSR_STALL, 32'h0);

    // Out of range writes alias onto a known word if the range check fails
    test_name = "out_of_range";
    a = addr_list[0];
    obi_xfer(1'b1, a + `OBI_MEM_WORDS * 4, 4'hf, next_random());
    obi_xfer(1'b0, a + `OBI_MEM_WORDS * 4, 4'hf, 32'h0);
    obi_xfer(1'b1, 32'hffff_fffc, 4'hf, next_random());
    obi_xfer(1'b0, a, 4'hf, 32'h0);
    wait_responses();

    test_name = "violations";
    cfg_write(CSR_STALL, {{(32-`OBI_STALL_WIDTH){1'b0}}, {`OBI_STALL_WIDTH{1'b1}}});
    @(negedge clk);
    check_value("gnt under full stall", 32'h0, {31'h0, gnt});
    a     = addr_list[1];
    r     = next_random();
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    be    = 4'hf;
    wdata = r;
    @(negedge clk);
    drive_stalled(1'b1, a + 32'd4, 4'hf, r);
    drive_stalled(1'b1, a + 32'd4, 4'h3, r);
    drive_stalled(1'b1, a + 32'd4, 4'h3, ~r);
    drive_stalled(1'b0, a + 32'd4, 4'h3, ~r);
    cfg_write(CSR_STALL, 32'h0);
    @(negedge clk);
    check_value("gnt without stall", 32'h1, {31'h0, gnt});
    xfer_violation(1'b1, a, 4'b0000, r);
    xfer_violation(1'b1, a, 4'b0101, r);
    xfer_violation(1'b1, a | 32'd3, 4'b0011, r);
    wait_responses();

    test_name = "csr_status";
    cfg_read(CSR_VIOL_COUNT, rd);
    check_value("violation count", viol_injected, rd);
    cfg_read(CSR_FIRST_VIOL, rd);
    check_value("first violation", {28'h0, first_code}, rd);
    check_value("monitor pulses", viol_injected, viol_seen);
    cfg_write(CSR_VIOL_COUNT, 32'h0);
    for (int n = 0; n < 4; n++) begin
      obi_xfer(1'b1, addr_list[n], random_be(), next_random());
      obi_xfer(1'b0, addr_list[n], 4'hf, 32'h0);
    end
    wait_responses();
    cfg_read(CSR_VIOL_COUNT, rd);
    check_value("count after clear", 32'h0, rd);
    cfg_read(CSR_FIRST_VIOL, rd);
    check_value("first code after clear", 32'h0, rd);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
hdl/obi_mem_pkg.sv
hdl/obi_mem_ctrl.sv
hdl/obi_protocol_monitor.sv
hdl/obi_mem_csr.sv
hdl/obi_mem_top.sv
verif/obi_mem_tb.sv

/* Makefile */
# Verilator flow for the OBI memory testbench

SIM = obj_dir/obi_mem_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f sources.f --top-module obi_mem_tb -Mdir obj_dir -o obi_mem_sim

# The simulator output goes to the log, and the pass line decides the status
run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
